// File: src/rvMultiParams.svh
`ifndef RV_MULTI_PARAMS_SVH
`define RV_MULTI_PARAMS_SVH

// machine word width in bits
`define RV_XLEN 32

// depth of the shared instruction and data memory in 32-bit words
`define RV_MEM_WORDS 1024

// address of the first fetch after start
`define RV_RESET_PC 32'h0000_0000

`endif

// File: src/rvMultiPkg.sv
`include "rvMultiParams.svh"

package rvMultiPkg;

    typedef logic [`RV_XLEN-1:0] wordT;                  // registers, alu, memory, pc
    typedef logic [4:0] regAddrT;                        // x0 to x31
    typedef logic [$clog2(`RV_MEM_WORDS)-1:0] memAddrT;  // word index, byte bits dropped

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opI      = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opLui    = 7'b0110111,
        opJal    = 7'b1101111,
        opSystem = 7'b1110011   // only ebreak is expected here
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,     // signed
        aluXor,
        aluSrl,
        aluOr,
        aluAnd,
        aluPassB    // lui
    } aluOpT;

    typedef enum logic [2:0] {
        stHalted,
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback
    } cpuStateT;

endpackage

// File: src/alu.sv
module alu (
    input  rvMultiPkg::aluOpT op,
    input  rvMultiPkg::wordT  a,
    input  rvMultiPkg::wordT  b,
    output rvMultiPkg::wordT  result,
    output logic              zero
);
    import rvMultiPkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // upper bits of the shift operand ignored

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluSll:   result = a << shamt;
            aluSlt:   result = wordT'($signed(a) < $signed(b));
            aluXor:   result = a ^ b;
            aluSrl:   result = a >> shamt;  // logical
            aluOr:    result = a | b;       // bitwise
            aluAnd:   result = a & b;
            aluPassB: result = b;           // upper immediate straight through
            default:  result = '0;
        endcase
    end

    // equality test for beq and bne after a subtract
    assign zero = (result == '0);

endmodule

// File: src/regFile.sv
module regFile (
    input  logic                clock,
    input  logic                rstN,
    input  logic                writeEn,
    input  rvMultiPkg::regAddrT rs1Addr,
    input  rvMultiPkg::regAddrT rs2Addr,
    input  rvMultiPkg::regAddrT rdAddr,
    input  rvMultiPkg::regAddrT dbgAddr,
    input  rvMultiPkg::wordT    rdData,
    output rvMultiPkg::wordT    rs1Data,
    output rvMultiPkg::wordT    rs2Data,
    output rvMultiPkg::wordT    dbgData
);
    import rvMultiPkg::*;

    wordT regs [32];

    // x0 cleared by reset and never written afterwards
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (rdAddr != '0)) begin
            regs[rdAddr] <= rdData;
        end
    end

    // all three reads are asynchronous
    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];
    assign dbgData = regs[dbgAddr];  // testbench view

endmodule

// File: src/programCounter.sv
`include "rvMultiParams.svh"

module programCounter (
    input  logic             clock,
    input  logic             rstN,
    input  logic             start,
    input  logic             pcInc,
    input  logic             pcBranch,
    input  logic             pcJump,
    input  logic             instRetire,
    input  rvMultiPkg::wordT target,
    output rvMultiPkg::wordT pc,
    output logic [31:0]      retired
);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= `RV_RESET_PC;
        end else if (start) begin
            pc <= `RV_RESET_PC;  // every run begins at the reset address
        end else if (pcBranch || pcJump) begin
            pc <= target;        // precomputed in decode
        end else if (pcInc) begin
            pc <= pc + 32'd4;
        end
    end

    // instructions retired since the last start
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            retired <= '0;
        end else if (start) begin
            retired <= '0;
        end else if (instRetire) begin
            retired <= retired + 32'd1;
        end
    end

    assert property (@(posedge clock) disable iff (!rstN) !(pcBranch && pcJump))
        else $error("branch and jump requested in the same cycle");

endmodule

// File: src/controlFsm.sv
module controlFsm (
    input  logic               clock,
    input  logic               rstN,
    input  logic               start,
    input  rvMultiPkg::opcodeT opcode,
    input  logic [2:0]         funct3,
    input  logic               funct7b5,
    input  logic               aluZero,
    output logic               halted,
    output logic               irLoad,
    output logic               operandLoad,
    output logic               aluOutLoad,
    output logic               regWrite,
    output logic               wbFromMem,
    output logic               memWrite,
    output logic               addrFromAlu,
    output logic               aluSrcImm,
    output logic               pcInc,
    output logic               pcBranch,
    output logic               pcJump,
    output logic               instRetire,
    output rvMultiPkg::aluOpT  aluOp
);
    import rvMultiPkg::*;

    cpuStateT state;
    cpuStateT stateNext;
    logic     branchTaken;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= stHalted;
        end else begin
            state <= stateNext;
        end
    end

    assign halted = (state == stHalted);

    // beq wants equal operands and bne wants them different
    always_comb begin
        case (funct3)
            3'b000:  branchTaken = aluZero;
            3'b001:  branchTaken = !aluZero;
            default: branchTaken = 1'b0;
        endcase
    end

    // immediate on operand b for everything but R-type and branches
    assign aluSrcImm = opcode inside {opI, opLoad, opStore, opLui};

    always_comb begin
        aluOp = aluAdd;  // loads and stores form their address by add
        case (opcode)
            opR, opI: begin
                case (funct3)
                    3'b000:  aluOp = (opcode == opR && funct7b5) ? aluSub : aluAdd;
                    3'b001:  aluOp = aluSll;
                    3'b010:  aluOp = aluSlt;
                    3'b100:  aluOp = aluXor;
                    3'b101:  aluOp = aluSrl;
                    3'b110:  aluOp = aluOr;
                    3'b111:  aluOp = aluAnd;
                    default: aluOp = aluAdd;
                endcase
            end
            opBranch: aluOp = aluSub;   // zero flag on equality
            opLui:    aluOp = aluPassB;
            default:  aluOp = aluAdd;
        endcase
    end

    always_comb begin
        stateNext   = state;
        irLoad      = 1'b0;
        operandLoad = 1'b0;
        aluOutLoad  = 1'b0;
        regWrite    = 1'b0;
        wbFromMem   = 1'b0;
        memWrite    = 1'b0;
        addrFromAlu = 1'b0;
        pcInc       = 1'b0;
        pcBranch    = 1'b0;
        pcJump      = 1'b0;
        instRetire  = 1'b0;
        case (state)
            stHalted: begin
                if (start) begin
                    stateNext = stFetch;
                end
            end
            stFetch: begin
                stateNext = stDecode;  // memory addressed by pc
            end
            stDecode: begin
                irLoad      = 1'b1;
                operandLoad = 1'b1;  // rs1, rs2 and branch target
                case (opcode)
                    opR, opI, opLoad, opStore, opLui, opBranch, opJal: stateNext = stExecute;
                    default: stateNext = stHalted;  // ebreak or unknown opcode
                endcase
            end
            stExecute: begin
                case (opcode)
                    opBranch: begin
                        pcBranch   = branchTaken;
                        pcInc      = !branchTaken;
                        instRetire = 1'b1;
                        stateNext  = stFetch;
                    end
                    opJal: begin
                        regWrite   = 1'b1;  // link pc + 4
                        pcJump     = 1'b1;
                        instRetire = 1'b1;
                        stateNext  = stFetch;
                    end
                    opLoad, opStore: begin
                        aluOutLoad = 1'b1;  // effective address
                        stateNext  = stMemory;
                    end
                    default: begin
                        aluOutLoad = 1'b1;
                        stateNext  = stWriteback;
                    end
                endcase
            end
            stMemory: begin
                addrFromAlu = 1'b1;
                if (opcode == opStore) begin
                    memWrite   = 1'b1;
                    pcInc      = 1'b1;
                    instRetire = 1'b1;
                    stateNext  = stFetch;
                end else begin
                    stateNext = stWriteback;  // read data lands next cycle
                end
            end
            stWriteback: begin
                regWrite   = 1'b1;
                wbFromMem  = (opcode == opLoad);
                pcInc      = 1'b1;
                instRetire = 1'b1;
                stateNext  = stFetch;
            end
            default: stateNext = stHalted;
        endcase
    end

    // one memory port and one register port never both written
    assert property (@(posedge clock) disable iff (!rstN) !(memWrite && regWrite))
        else $error("memWrite and regWrite active together");

    // a halted core leaves the datapath untouched
    assert property (@(posedge clock) disable iff (!rstN)
        halted |-> !(irLoad || operandLoad || aluOutLoad || regWrite || memWrite ||
                     pcInc || pcBranch || pcJump || instRetire))
        else $error("datapath enable active while halted");

endmodule

// File: src/unifiedMemory.sv
`include "rvMultiParams.svh"

module unifiedMemory (
    input  logic                clock,
    input  logic                writeEn,
    input  rvMultiPkg::memAddrT addr,
    input  rvMultiPkg::wordT    writeData,
    output rvMultiPkg::wordT    readData
);
    import rvMultiPkg::*;

    wordT mem [`RV_MEM_WORDS];

    // one port for fetch, load, store and program loading
    always_ff @(posedge clock) begin
        if (writeEn) begin
            mem[addr] <= writeData;
        end
        readData <= mem[addr];  // old contents on a same-cycle write
    end

endmodule

// File: src/rvMultiCore.sv
module rvMultiCore (
    input  logic                clock,
    input  logic                rstN,
    input  logic                start,
    input  logic                loadEn,
    input  rvMultiPkg::memAddrT loadAddr,
    input  rvMultiPkg::wordT    loadData,
    input  rvMultiPkg::regAddrT dbgAddr,
    output logic                halted,
    output rvMultiPkg::wordT    dbgData,
    output logic [31:0]         retired
);
    import rvMultiPkg::*;

    logic    irLoad;
    logic    operandLoad;
    logic    aluOutLoad;
    logic    regWrite;
    logic    wbFromMem;
    logic    memWrite;
    logic    addrFromAlu;
    logic    aluSrcImm;
    logic    pcInc;
    logic    pcBranch;
    logic    pcJump;
    logic    instRetire;
    logic    aluZero;
    logic    startRun;
    aluOpT   aluOp;
    opcodeT  opcode;

    wordT    irReg;
    wordT    ir;
    wordT    rs1Reg;
    wordT    rs2Reg;
    wordT    aluOut;
    wordT    targetReg;
    wordT    imm;
    wordT    aluB;
    wordT    aluResult;
    wordT    wbData;
    wordT    pc;
    wordT    rs1Data;
    wordT    rs2Data;
    wordT    memReadData;
    wordT    memWriteData;
    memAddrT memAddr;
    logic    memWriteEn;

    assign startRun = start && halted;  // ignored while running

    // decode reads the fetched word straight off the memory port
    assign ir     = irLoad ? memReadData : irReg;
    assign opcode = opcodeT'(ir[6:0]);

    // one sign-extended immediate per format
    always_comb begin
        case (opcode)
            opStore:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            opBranch: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            opLui:    imm = {ir[31:12], 12'b0};
            opJal:    imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:  imm = {{20{ir[31]}}, ir[31:20]};  // I format, slli shamt in low bits
        endcase
    end

    // payload registers with no reset
    always_ff @(posedge clock) begin
        if (irLoad) begin
            irReg <= memReadData;
        end
        if (operandLoad) begin
            rs1Reg    <= rs1Data;
            rs2Reg    <= rs2Data;      // also the store data
            targetReg <= pc + imm;     // pc still holds the fetch address
        end
        if (aluOutLoad) begin
            aluOut <= aluResult;
        end
    end

    assign aluB = aluSrcImm ? imm : rs2Reg;

    // jal links the address after itself
    assign wbData = wbFromMem ? memReadData : ((opcode == opJal) ? pc + 32'd4 : aluOut);

    // external load port owns the memory while halted
    assign memAddr      = halted ? loadAddr :
                          (addrFromAlu ? memAddrT'(aluOut >> 2) : memAddrT'(pc >> 2));
    assign memWriteEn   = halted ? loadEn : memWrite;
    assign memWriteData = halted ? loadData : rs2Reg;

    controlFsm controlFsm_i (
        .clock       (clock),
        .rstN        (rstN),
        .start       (startRun),
        .opcode      (opcode),
        .funct3      (ir[14:12]),
        .funct7b5    (ir[30]),
        .aluZero     (aluZero),
        .halted      (halted),
        .irLoad      (irLoad),
        .operandLoad (operandLoad),
        .aluOutLoad  (aluOutLoad),
        .regWrite    (regWrite),
        .wbFromMem   (wbFromMem),
        .memWrite    (memWrite),
        .addrFromAlu (addrFromAlu),
        .aluSrcImm   (aluSrcImm),
        .pcInc       (pcInc),
        .pcBranch    (pcBranch),
        .pcJump      (pcJump),
        .instRetire  (instRetire),
        .aluOp       (aluOp)
    );

    programCounter programCounter_i (
        .clock      (clock),
        .rstN       (rstN),
        .start      (startRun),
        .pcInc      (pcInc),
        .pcBranch   (pcBranch),
        .pcJump     (pcJump),
        .instRetire (instRetire),
        .target     (targetReg),
        .pc         (pc),
        .retired    (retired)
    );

    regFile regFile_i (
        .clock   (clock),
        .rstN    (rstN),
        .writeEn (regWrite),
        .rs1Addr (ir[19:15]),
        .rs2Addr (ir[24:20]),
        .rdAddr  (ir[11:7]),
        .dbgAddr (dbgAddr),
        .rdData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .dbgData (dbgData)
    );

    alu alu_i (
        .op     (aluOp),
        .a      (rs1Reg),
        .b      (aluB),
        .result (aluResult),
        .zero   (aluZero)
    );

    unifiedMemory unifiedMemory_i (
        .clock     (clock),
        .writeEn   (memWriteEn),
        .addr      (memAddr),
        .writeData (memWriteData),
        .readData  (memReadData)
    );

    // ebreak seen in decode stops the core on the next cycle
    assert property (@(posedge clock) disable iff (!rstN)
        (irLoad && (opcode == opSystem)) |=> halted)
        else $error("ebreak did not halt the core");

endmodule

// File: verif/rvMultiModel.svh
`ifndef RV_MULTI_MODEL_SVH
`define RV_MULTI_MODEL_SVH

wordT        progImage [`RV_MEM_WORDS];  // whole memory image, loaded before each run
wordT        modelMem [`RV_MEM_WORDS];
wordT        modelRegs [32];             // kept across runs, same as the core's registers
int unsigned modelRetired;
int          progLen;

// immediate formats of the base ISA, all sign extended
function automatic wordT iImmediate(input wordT ins);
    return {{20{ins[31]}}, ins[31:20]};
endfunction

function automatic wordT sImmediate(input wordT ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
endfunction

function automatic wordT bImmediate(input wordT ins);
    return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
endfunction

function automatic wordT uImmediate(input wordT ins);
    return {ins[31:12], 12'h000};
endfunction

function automatic wordT jImmediate(input wordT ins);
    return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
endfunction

// funct3 picks the operation, alt is funct7 bit 5 of an R-type
function automatic wordT computeAlu(input logic [2:0] f3, input logic alt,
                                    input wordT a, input wordT b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];  // low five bits only
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return a >> b[4:0];
        3'b110:  return a | b;
        3'b111:  return a & b;
        default: return a + b;
    endcase
endfunction

// runs progImage to ebreak, 1 when it got there
function automatic bit executeProgram();
    wordT    pc;
    wordT    ins;
    wordT    a;
    wordT    b;
    wordT    res;
    regAddrT rd;
    bit      writes;
    bit      done;
    int      steps;
    pc           = `RV_RESET_PC;
    done         = 1'b0;
    steps        = 0;
    modelRetired = 0;
    for (int i = 0; i < `RV_MEM_WORDS; i++) begin
        modelMem[i] = progImage[i];
    end
    while (!done && steps < maxSteps) begin
        ins    = modelMem[memAddrT'(pc >> 2)];
        rd     = ins[11:7];
        a      = modelRegs[ins[19:15]];
        b      = modelRegs[ins[24:20]];
        res    = '0;
        writes = 1'b1;
        steps++;
        case (ins[6:0])
            opR: begin
                res = computeAlu(ins[14:12], ins[30], a, b);
                pc  = pc + 32'd4;
            end
            opI: begin
                res = computeAlu(ins[14:12], 1'b0, a, iImmediate(ins));  // no subi
                pc  = pc + 32'd4;
            end
            opLoad: begin
                res = modelMem[memAddrT'((a + iImmediate(ins)) >> 2)];
                pc  = pc + 32'd4;
            end
            opStore: begin
                writes = 1'b0;
                modelMem[memAddrT'((a + sImmediate(ins)) >> 2)] = b;
                pc = pc + 32'd4;
            end
            opLui: begin
                res = uImmediate(ins);
                pc  = pc + 32'd4;
            end
            opJal: begin
                res = pc + 32'd4;  // link
                pc  = pc + jImmediate(ins);
            end
            opBranch: begin
                writes = 1'b0;
                if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                    pc = pc + bImmediate(ins);
                end else begin
                    pc = pc + 32'd4;
                end
            end
            default: begin
                writes = 1'b0;  // ebreak, or anything else, stops
                done   = 1'b1;
            end
        endcase
        if (writes && rd != 5'd0) begin
            modelRegs[rd] = res;
        end
        if (!done) begin
            modelRetired++;
        end
    end
    return done;
endfunction

// instruction encoders
function automatic wordT rFormat(input logic [6:0] f7, input regAddrT rs2, input regAddrT rs1,
                                 input logic [2:0] f3, input regAddrT rd);
    return {f7, rs2, rs1, f3, rd, opR};
endfunction

function automatic wordT iFormat(input logic [11:0] imm, input regAddrT rs1,
                                 input logic [2:0] f3, input regAddrT rd, input opcodeT op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic wordT sFormat(input logic [11:0] imm, input regAddrT rs2, input regAddrT rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};  // sw only
endfunction

function automatic wordT bFormat(input logic [12:0] imm, input regAddrT rs2, input regAddrT rs1,
                                 input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic wordT uFormat(input logic [19:0] imm, input regAddrT rd);
    return {imm, rd, opLui};
endfunction

function automatic wordT jFormat(input logic [20:0] imm, input regAddrT rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

function automatic wordT randomWord();
    return $random(seed);
endfunction

// register index from lo to 31
function automatic regAddrT pickReg(input int lo);
    return regAddrT'(lo + int'($unsigned($random(seed)) % (32 - lo)));
endfunction

// background words differ at every address
function automatic void fillImage();
    for (int i = 0; i < `RV_MEM_WORDS; i++) begin
        progImage[i] = (wordT'(i) * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
    end
    progLen = 0;
endfunction

function automatic void appendWord(input wordT w);
    progImage[progLen] = w;
    progLen++;
endfunction

function automatic void rTypeProgram();
    logic [2:0] f3;
    logic [6:0] f7;
    wordT       r;
    fillImage();
    for (int i = 1; i < 32; i++) begin
        appendWord(iFormat(12'(randomWord()), 5'd0, 3'b000, regAddrT'(i), opI));  // addi seed
    end
    for (int k = 0; k < 40; k++) begin
        r  = randomWord();
        f3 = (r[2:0] == 3'b011) ? 3'b000 : r[2:0];  // no sltu in the subset
        f7 = (f3 == 3'b000 && r[3]) ? 7'h20 : 7'h00;
        appendWord(rFormat(f7, pickReg(0), pickReg(0), f3, (k % 9 == 8) ? 5'd0 : pickReg(1)));
    end
    appendWord(ebreakWord);
endfunction

function automatic void iTypeProgram();
    logic [11:0] imm;
    logic [2:0]  f3;
    wordT        r;
    int          kind;
    fillImage();
    for (int i = 1; i < 32; i++) begin
        appendWord(iFormat(12'(randomWord()), 5'd0, 3'b000, regAddrT'(i), opI));
    end
    for (int k = 0; k < 40; k++) begin
        r    = randomWord();
        kind = int'(r % 32'd6);
        imm  = r[11:0];
        if (k % 4 != 3) begin
            imm[11] = 1'b1;  // mostly negative
        end
        case (kind)
            0: f3 = 3'b000;
            1: f3 = 3'b100;
            2: f3 = 3'b110;
            3: f3 = 3'b111;
            4: begin
                f3  = 3'b001;
                imm = {7'b0, r[16:12]};
            end
            default: begin
                f3  = 3'b101;
                imm = {7'b0, r[16:12]};
            end
        endcase
        appendWord(iFormat(imm, pickReg(0), f3, (k % 5 == 0) ? 5'd0 : pickReg(1), opI));
    end
    appendWord(ebreakWord);
endfunction

function automatic void memoryProgram();
    logic [11:0] offs [12];
    wordT        r;
    wordT        data;
    regAddrT     rd;
    fillImage();
    appendWord(uFormat(20'd1, 5'd31));  // x31 = 0x1000, negative offsets reach the data half
    for (int k = 0; k < 12; k++) begin
        r       = randomWord();
        data    = randomWord();
        rd      = regAddrT'(k + 1);
        offs[k] = 12'(-4 * (1 + int'(r[8:0])));  // 0x800 up to 0xffc
        appendWord(uFormat(data[31:12], rd));
        appendWord(iFormat(data[11:0], rd, 3'b000, rd, opI));
        appendWord(sFormat(offs[k], rd, 5'd31));
    end
    data = randomWord();
    appendWord(uFormat(data[31:12], 5'd30));  // bare lui, low bits zero
    for (int k = 0; k < 12; k++) begin
        appendWord(iFormat(offs[k], 5'd31, 3'b010, regAddrT'(k + 13), opLoad));  // lw readback
    end
    appendWord(ebreakWord);
endfunction

// countdown with skipped words after each jump and taken branch
function automatic void loopProgram();
    logic [11:0] count;
    count = 12'(3 + int'(randomWord() % 32'd6));
    fillImage();
    appendWord(iFormat(count, 5'd0, 3'b000, 5'd1, opI));
    appendWord(iFormat(12'd0, 5'd0, 3'b000, 5'd2, opI));
    appendWord(iFormat(12'd0, 5'd0, 3'b000, 5'd3, opI));
    appendWord(iFormat(12'd3, 5'd2, 3'b000, 5'd2, opI));    // 0x0c loop top
    appendWord(jFormat(21'd8, 5'd4));
    appendWord(iFormat(12'd100, 5'd3, 3'b000, 5'd3, opI));  // skipped
    appendWord(iFormat(12'hfff, 5'd1, 3'b000, 5'd1, opI));  // count down
    appendWord(bFormat(13'h1ff0, 5'd0, 5'd1, 3'b001));      // bne back to 0x0c
    appendWord(bFormat(13'd8, 5'd0, 5'd1, 3'b000));         // beq taken
    appendWord(iFormat(12'd1, 5'd3, 3'b000, 5'd3, opI));    // skipped
    appendWord(jFormat(21'd8, 5'd5));
    appendWord(iFormat(12'd7, 5'd0, 3'b000, 5'd6, opI));    // skipped
    appendWord(bFormat(13'd8, 5'd0, 5'd2, 3'b000));         // beq not taken
    appendWord(iFormat(12'd9, 5'd0, 3'b000, 5'd7, opI));
    appendWord(jFormat(21'd8, 5'd0));                       // link to x0 dropped
    appendWord(iFormat(12'd5, 5'd0, 3'b000, 5'd8, opI));    // skipped
    appendWord(ebreakWord);
endfunction

`endif

// File: verif/rvMultiTb.sv
`include "rvMultiParams.svh"

module rvMultiTb;
    timeunit 1ns;
    timeprecision 100ps;
    import rvMultiPkg::*;

    localparam int   maxSteps   = 300;  // model guard per program
    localparam int   numRuns    = 6;    // reset sweep plus five programs
    localparam int   runCycles  = `RV_MEM_WORDS + 2 + 5 * maxSteps + 2 * 32 + 40;
    localparam int   cycleLimit = numRuns * runCycles + 200;
    localparam wordT ebreakWord = 32'h0010_0073;

    logic    clock = 1'b0;
    logic    rstN;
    logic    start;
    logic    loadEn;
    memAddrT loadAddr;
    wordT    loadData;
    regAddrT dbgAddr;
    logic    halted;
    wordT    dbgData;
    logic [31:0] retired;

    integer seed;
    int     mismatchCount = 0;
    int     failCount = 0;
    int     cycleCount = 0;

    `include "rvMultiModel.svh"

    rvMultiCore rvMultiCore_i (
        .clock    (clock),
        .rstN     (rstN),
        .start    (start),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .dbgAddr  (dbgAddr),
        .halted   (halted),
        .dbgData  (dbgData),
        .retired  (retired)
    );

    always #10 clock = ~clock;  // 20 ns period

    // hard stop for a hung core
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkCount(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // debug port is combinational, read back half a cycle later
    task automatic compareRegisters(input string name);
        for (int i = 0; i < 32; i++) begin
            @(posedge clock);
            dbgAddr <= regAddrT'(i);
            @(negedge clock);
            checkWord($sformatf("%s x%0d", name, i), modelRegs[i], dbgData);
        end
    endtask

    task automatic loadMemory();
        for (int i = 0; i < `RV_MEM_WORDS; i++) begin
            @(posedge clock);
            loadEn   <= 1'b1;
            loadAddr <= memAddrT'(i);
            loadData <= progImage[i];
        end
        @(posedge clock);
        loadEn <= 1'b0;
    endtask

    task automatic loadAndRun(input string name);
        int waited;
        int limit;
        bit finished;
        finished = executeProgram();  // expected state first
        if (!finished) begin
            failCount++;
            $display("%s: reference model never reached ebreak", name);
        end
        loadMemory();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        @(negedge clock);  // core in fetch now
        if (halted) begin
            failCount++;
            $display("%s: core stayed halted after the start pulse", name);
        end
        checkCount({name, " retired after start"}, 32'd0, retired);
        limit  = 5 * int'(modelRetired) + 20;
        waited = 0;
        while (!halted && waited < limit) begin
            @(negedge clock);
            waited++;
        end
        if (!halted) begin
            failCount++;
            $display("%s: halted did not rise within %0d cycles", name, limit);
        end else begin
            compareRegisters(name);
            checkCount({name, " retired"}, modelRetired, retired);
        end
    endtask

    initial begin
        seed     = 32'haaee6e41;
        rstN     = 1'b0;
        start    = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        dbgAddr  = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (3) @(posedge clock);
        rstN <= 1'b1;
        @(negedge clock);

        if (!halted) begin
            failCount++;
            $display("reset: halted is low after reset");
        end
        checkCount("reset retired", 32'd0, retired);
        compareRegisters("reset");

        rTypeProgram();
        loadAndRun("rtype");
        iTypeProgram();
        loadAndRun("itype");
        memoryProgram();
        loadAndRun("memory");
        loopProgram();
        loadAndRun("loop");
        loopProgram();  // second load and start on a halted core
        loadAndRun("rerun");

        $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: rvMulti.f
+incdir+src
+incdir+verif
src/rvMultiPkg.sv
src/alu.sv
src/regFile.sv
src/programCounter.sv
src/controlFsm.sv
src/unifiedMemory.sv
src/rvMultiCore.sv
verif/rvMultiTb.sv

// File: Makefile
TOP = rvMultiTb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f rvMulti.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean
